// File: Makefile
TOOL    = verilator
FLAGS   = --binary --timing --assert -j 0
TOP     = tb_l2_mshr
FLIST   = l2_mshr.f
OBJ_DIR = obj_dir
LOG     = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^sim passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/mshr_ref_model.svh
`ifndef MSHR_REF_MODEL_SVH
`define MSHR_REF_MODEL_SVH

// shadow copy of the entry table
mshr_pkg::spx_state_e m_state [mshr_pkg::N_MSHR];
mshr_pkg::l2_tag_t    m_tag   [mshr_pkg::N_MSHR];
mshr_pkg::l2_set_t    m_set   [mshr_pkg::N_MSHR];
mshr_pkg::line_t      m_line  [mshr_pkg::N_MSHR];
mshr_pkg::word_mask_t m_mask  [mshr_pkg::N_MSHR];
// latched result as the DUT should hold it now
mshr_pkg::mshr_idx_t  m_idx;
logic                 m_hit;
// predictions for the operation of this cycle
logic                 exp_set_conf;
logic                 exp_clr_conf;
logic                 exp_set_stall;
logic                 exp_clr_stall;
mshr_pkg::mshr_idx_t  exp_stall_idx;
mshr_pkg::mshr_idx_t  nxt_idx;
logic                 nxt_hit;

task automatic reset_model();
    for (int i = 0; i < mshr_pkg::N_MSHR; i++) begin
        m_state[i] = mshr_pkg::SPX_I;
        m_tag[i]   = '0;
        m_set[i]   = '0;
        m_line[i]  = '0;
        m_mask[i]  = '0;
    end
    m_idx = '0;
    m_hit = 1'b0;
endtask

// strobes for now and index and hit for the coming edge
task automatic predict_search(input mshr_pkg::mshr_op_e op, input mshr_pkg::l2_tag_t tag,
                              input mshr_pkg::l2_set_t set, input mshr_pkg::fwd_msg_e fwd);
    logic                hit;
    logic                same_set;
    logic                no_stall;
    mshr_pkg::mshr_idx_t hit_idx;
    mshr_pkg::mshr_idx_t free_idx;
    hit      = 1'b0;
    same_set = 1'b0;
    hit_idx  = '0;
    free_idx = '0;
    // later entries overwrite, so the highest index wins
    for (int i = 0; i < mshr_pkg::N_MSHR; i++) begin
        if (m_state[i] == mshr_pkg::SPX_I) begin
            free_idx = mshr_pkg::mshr_idx_t'(i);
        end else if (m_set[i] == set) begin
            same_set = 1'b1;
            if (m_tag[i] == tag) begin
                hit     = 1'b1;
                hit_idx = mshr_pkg::mshr_idx_t'(i);
            end
        end
    end
    // inv never stalls and ownership or share requests skip a line in RI
    no_stall = (fwd == mshr_pkg::FWD_INV) ||
               ((fwd inside {mshr_pkg::FWD_RVK_O, mshr_pkg::FWD_REQ_S, mshr_pkg::FWD_REQ_ODATA})
                && (m_state[hit_idx] == mshr_pkg::SPX_RI));
    exp_set_conf  = (op == mshr_pkg::MSHR_PEEK_REQ) && same_set;
    exp_clr_conf  = (op == mshr_pkg::MSHR_PEEK_REQ) && !same_set;
    exp_set_stall = (op == mshr_pkg::MSHR_PEEK_FWD) && hit && !no_stall;
    exp_clr_stall = (op == mshr_pkg::MSHR_PEEK_FWD) && !(hit && !no_stall);
    exp_stall_idx = hit_idx;
    nxt_idx = m_idx;
    nxt_hit = m_hit;
    case (op)
        mshr_pkg::MSHR_LOOKUP, mshr_pkg::MSHR_PEEK_FWD: begin
            nxt_idx = hit_idx;
            nxt_hit = hit;
        end
        mshr_pkg::MSHR_PEEK_REQ, mshr_pkg::MSHR_PEEK_FLUSH: begin
            nxt_idx = free_idx;
            nxt_hit = 1'b0;
        end
        default: begin
            nxt_hit = m_hit;
        end
    endcase
endtask

// write kind codes 1 add, 2 state, 3 tag, 4 line, 5 mask
task automatic commit_model(input int kind, input mshr_pkg::mshr_op_e op,
                            input mshr_pkg::spx_state_e state, input mshr_pkg::l2_tag_t tag,
                            input mshr_pkg::l2_set_t set, input mshr_pkg::line_t line,
                            input mshr_pkg::word_mask_t mask);
    // writes go to the index latched before this edge
    if (kind == 1 || kind == 2) begin
        m_state[m_idx] = state;
    end
    if (kind == 1 || kind == 3) begin
        m_tag[m_idx] = tag;
    end
    if (kind == 1) begin
        m_set[m_idx] = set;
    end
    if (kind == 1 || kind == 4) begin
        m_line[m_idx] = line;
    end
    if (kind == 1 || kind == 5) begin
        m_mask[m_idx] = mask;
    end
    if (op != mshr_pkg::MSHR_IDLE) begin
        m_idx = nxt_idx;
        m_hit = nxt_hit;
    end
endtask

function automatic logic pending_expected();
    logic busy;
    busy = 1'b0;
    for (int i = 0; i < mshr_pkg::N_MSHR; i++) begin
        if (m_state[i] inside {mshr_pkg::SPX_XR, mshr_pkg::SPX_XRV, mshr_pkg::SPX_AMO}) begin
            busy = 1'b1;
        end
    end
    return busy;
endfunction

`endif

// File: bench/tb_l2_mshr.sv
`timescale 1ns/1ps

module tb_l2_mshr;

    localparam int RESET_CYCLES = 8;
    localparam int RUN_CYCLES   = 2000;
    localparam int CYCLE_LIMIT  = RESET_CYCLES + RUN_CYCLES + 100;

    logic                 clk;
    logic                 rst;
    mshr_pkg::mshr_op_e   op_i;
    mshr_pkg::l2_tag_t    tag_i;
    mshr_pkg::l2_set_t    set_i;
    mshr_pkg::fwd_msg_e   fwd_msg_i;
    logic                 add_entry_i;
    logic                 upd_state_i;
    logic                 upd_tag_i;
    logic                 upd_line_i;
    logic                 upd_word_mask_i;
    mshr_pkg::spx_state_e state_i;
    mshr_pkg::line_t      line_i;
    mshr_pkg::word_mask_t word_mask_i;
    mshr_pkg::mshr_idx_t  rd_idx_i;
    logic                 set_conflict_o;
    logic                 clr_conflict_o;
    logic                 set_fwd_stall_o;
    logic                 clr_fwd_stall_o;
    mshr_pkg::mshr_idx_t  stall_idx_o;
    mshr_pkg::mshr_idx_t  mshr_idx_o;
    logic                 mshr_hit_o;
    mshr_pkg::spx_state_e rd_state_o;
    mshr_pkg::l2_tag_t    rd_tag_o;
    mshr_pkg::l2_set_t    rd_set_o;
    mshr_pkg::line_t      rd_line_o;
    mshr_pkg::word_mask_t rd_word_mask_o;
    logic                 write_pending_o;

    integer seed;
    int     errors = 0;
    int     checks = 0;
    int     cycles = 0;
    // write kind driven this cycle
    int     wr_kind;

    `include "mshr_ref_model.svh"

    l2_mshr i_l2_mshr (
        .clk             (clk),
        .rst             (rst),
        .op_i            (op_i),
        .tag_i           (tag_i),
        .set_i           (set_i),
        .fwd_msg_i       (fwd_msg_i),
        .add_entry_i     (add_entry_i),
        .upd_state_i     (upd_state_i),
        .upd_tag_i       (upd_tag_i),
        .upd_line_i      (upd_line_i),
        .upd_word_mask_i (upd_word_mask_i),
        .state_i         (state_i),
        .line_i          (line_i),
        .word_mask_i     (word_mask_i),
        .rd_idx_i        (rd_idx_i),
        .set_conflict_o  (set_conflict_o),
        .clr_conflict_o  (clr_conflict_o),
        .set_fwd_stall_o (set_fwd_stall_o),
        .clr_fwd_stall_o (clr_fwd_stall_o),
        .stall_idx_o     (stall_idx_o),
        .mshr_idx_o      (mshr_idx_o),
        .mshr_hit_o      (mshr_hit_o),
        .rd_state_o      (rd_state_o),
        .rd_tag_o        (rd_tag_o),
        .rd_set_o        (rd_set_o),
        .rd_line_o       (rd_line_o),
        .rd_word_mask_o  (rd_word_mask_o),
        .write_pending_o (write_pending_o)
    );

    // 40 ns clock
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // hard stop in case the run stalls
    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("sim failed");
            $finish;
        end
    end

    task automatic check_bit(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_idx(input mshr_pkg::mshr_idx_t got, input mshr_pkg::mshr_idx_t exp,
                             input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_state(input mshr_pkg::spx_state_e got, input mshr_pkg::spx_state_e exp,
                               input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s got %s expected %s", $time, what, got.name(),
                     exp.name());
        end
    endtask

    task automatic check_tag(input mshr_pkg::l2_tag_t got, input mshr_pkg::l2_tag_t exp,
                             input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_set(input mshr_pkg::l2_set_t got, input mshr_pkg::l2_set_t exp,
                             input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_line(input mshr_pkg::line_t got, input mshr_pkg::line_t exp,
                              input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_mask(input mshr_pkg::word_mask_t got, input mshr_pkg::word_mask_t exp,
                              input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    // one random operation plus at most one write
    task automatic drive_random();
        int kind;
        kind = int'($unsigned($random(seed)) % 8);
        // 4 tags and 4 sets so hits and conflicts come often
        op_i        = mshr_pkg::mshr_op_e'(3'($unsigned($random(seed)) % 5));
        tag_i       = 12'h3a0 + mshr_pkg::l2_tag_t'($unsigned($random(seed)) % 4);
        set_i       = 6'd8 + mshr_pkg::l2_set_t'($unsigned($random(seed)) % 4);
        fwd_msg_i   = mshr_pkg::fwd_msg_e'(3'($unsigned($random(seed)) % 5));
        line_i      = {$random(seed), $random(seed), $random(seed), $random(seed)};
        word_mask_i = mshr_pkg::word_mask_t'($random(seed));
        rd_idx_i    = mshr_pkg::mshr_idx_t'($random(seed));
        // an add only lands on a free slot
        if (kind == 1 && m_state[m_idx] != mshr_pkg::SPX_I) begin
            kind = 0;
        end
        if (kind == 1) begin
            state_i = mshr_pkg::spx_state_e'(4'(1 + $unsigned($random(seed)) % 6));
        end else begin
            state_i = mshr_pkg::spx_state_e'(4'($unsigned($random(seed)) % 7));
        end
        add_entry_i     = (kind == 1);
        upd_state_i     = (kind == 2);
        upd_tag_i       = (kind == 3);
        upd_line_i      = (kind == 4);
        upd_word_mask_i = (kind == 5);
        wr_kind         = kind;
    endtask

    // outputs late in the cycle against the model
    task automatic check_cycle();
        predict_search(op_i, tag_i, set_i, fwd_msg_i);
        check_bit(set_conflict_o, exp_set_conf, "set_conflict_o");
        check_bit(clr_conflict_o, exp_clr_conf, "clr_conflict_o");
        check_bit(set_fwd_stall_o, exp_set_stall, "set_fwd_stall_o");
        check_bit(clr_fwd_stall_o, exp_clr_stall, "clr_fwd_stall_o");
        if (exp_set_stall) begin
            check_idx(stall_idx_o, exp_stall_idx, "stall_idx_o");
        end
        check_idx(mshr_idx_o, m_idx, "mshr_idx_o");
        check_bit(mshr_hit_o, m_hit, "mshr_hit_o");
        check_state(rd_state_o, m_state[rd_idx_i], "rd_state_o");
        check_tag(rd_tag_o, m_tag[rd_idx_i], "rd_tag_o");
        check_set(rd_set_o, m_set[rd_idx_i], "rd_set_o");
        check_line(rd_line_o, m_line[rd_idx_i], "rd_line_o");
        check_mask(rd_word_mask_o, m_mask[rd_idx_i], "rd_word_mask_o");
        check_bit(write_pending_o, pending_expected(), "write_pending_o");
    endtask

    initial begin
        seed            = 32'hfee4;
        rst             = 1'b0;
        op_i            = mshr_pkg::MSHR_IDLE;
        tag_i           = '0;
        set_i           = '0;
        fwd_msg_i       = mshr_pkg::FWD_INV;
        add_entry_i     = 1'b0;
        upd_state_i     = 1'b0;
        upd_tag_i       = 1'b0;
        upd_line_i      = 1'b0;
        upd_word_mask_i = 1'b0;
        state_i         = mshr_pkg::SPX_I;
        line_i          = '0;
        word_mask_i     = '0;
        rd_idx_i        = '0;
        wr_kind         = 0;
        reset_model();
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        // empty table straight out of reset
        for (int i = 0; i < mshr_pkg::N_MSHR; i++) begin
            rd_idx_i = mshr_pkg::mshr_idx_t'(i);
            #1;
            check_cycle();
        end
        rst = 1'b1;
        for (int c = 0; c < RUN_CYCLES; c++) begin
            @(posedge clk);
            #2;
            drive_random();
            #28;
            check_cycle();
            commit_model(wr_kind, op_i, state_i, tag_i, set_i, line_i, word_mask_i);
        end
        $display("closing: %0d errors in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: design/l2_mshr.sv
`timescale 1ns/1ps

module l2_mshr (
    input  logic                    clk,
    input  logic                    rst,
    // operation
    input  mshr_pkg::mshr_op_e      op_i,
    input  mshr_pkg::l2_tag_t       tag_i,
    input  mshr_pkg::l2_set_t       set_i,
    input  mshr_pkg::fwd_msg_e      fwd_msg_i,
    // writes at the latched index
    input  logic                    add_entry_i,
    input  logic                    upd_state_i,
    input  logic                    upd_tag_i,
    input  logic                    upd_line_i,
    input  logic                    upd_word_mask_i,
    input  mshr_pkg::spx_state_e    state_i,
    input  mshr_pkg::line_t         line_i,
    input  mshr_pkg::word_mask_t    word_mask_i,
    input  mshr_pkg::mshr_idx_t     rd_idx_i,
    // search results
    output logic                    set_conflict_o,
    output logic                    clr_conflict_o,
    output logic                    set_fwd_stall_o,
    output logic                    clr_fwd_stall_o,
    output mshr_pkg::mshr_idx_t     stall_idx_o,
    output mshr_pkg::mshr_idx_t     mshr_idx_o,
    output logic                    mshr_hit_o,
    // read port
    output mshr_pkg::spx_state_e    rd_state_o,
    output mshr_pkg::l2_tag_t       rd_tag_o,
    output mshr_pkg::l2_set_t       rd_set_o,
    output mshr_pkg::line_t         rd_line_o,
    output mshr_pkg::word_mask_t    rd_word_mask_o,
    output logic                    write_pending_o
);

    // entry view shared between table and search
    mshr_pkg::spx_state_e entry_state [mshr_pkg::N_MSHR];
    mshr_pkg::l2_tag_t    entry_tag   [mshr_pkg::N_MSHR];
    mshr_pkg::l2_set_t    entry_set   [mshr_pkg::N_MSHR];

    // writes land at the index latched by the last operation
    mshr_entry_table i_table (
        .clk             (clk),
        .rst             (rst),
        .add_entry_i     (add_entry_i),
        .upd_state_i     (upd_state_i),
        .upd_tag_i       (upd_tag_i),
        .upd_line_i      (upd_line_i),
        .upd_word_mask_i (upd_word_mask_i),
        .wr_idx_i        (mshr_idx_o),
        .state_i         (state_i),
        .tag_i           (tag_i),
        .set_i           (set_i),
        .line_i          (line_i),
        .word_mask_i     (word_mask_i),
        .rd_idx_i        (rd_idx_i),
        .state_o         (entry_state),
        .tag_o           (entry_tag),
        .set_o           (entry_set),
        .rd_state_o      (rd_state_o),
        .rd_tag_o        (rd_tag_o),
        .rd_set_o        (rd_set_o),
        .rd_line_o       (rd_line_o),
        .rd_word_mask_o  (rd_word_mask_o),
        .write_pending_o (write_pending_o)
    );

    mshr_search i_search (
        .clk             (clk),
        .rst             (rst),
        .op_i            (op_i),
        .tag_i           (tag_i),
        .set_i           (set_i),
        .fwd_msg_i       (fwd_msg_i),
        .state_i         (entry_state),
        .tag_e_i         (entry_tag),
        .set_e_i         (entry_set),
        .set_conflict_o  (set_conflict_o),
        .clr_conflict_o  (clr_conflict_o),
        .set_fwd_stall_o (set_fwd_stall_o),
        .clr_fwd_stall_o (clr_fwd_stall_o),
        .stall_idx_o     (stall_idx_o),
        .mshr_idx_o      (mshr_idx_o),
        .mshr_hit_o      (mshr_hit_o)
    );

endmodule

// File: design/mshr_entry_table.sv
`timescale 1ns/1ps

module mshr_entry_table (
    input  logic                       clk,
    input  logic                       rst,
    // add writes every field, upd_* write one field
    input  logic                       add_entry_i,
    input  logic                       upd_state_i,
    input  logic                       upd_tag_i,
    input  logic                       upd_line_i,
    input  logic                       upd_word_mask_i,
    input  mshr_pkg::mshr_idx_t        wr_idx_i,
    // write values
    input  mshr_pkg::spx_state_e       state_i,
    input  mshr_pkg::l2_tag_t          tag_i,
    input  mshr_pkg::l2_set_t          set_i,
    input  mshr_pkg::line_t            line_i,
    input  mshr_pkg::word_mask_t       word_mask_i,
    // read port select
    input  mshr_pkg::mshr_idx_t        rd_idx_i,
    // search view of all entries
    output mshr_pkg::spx_state_e       state_o [mshr_pkg::N_MSHR],
    output mshr_pkg::l2_tag_t          tag_o   [mshr_pkg::N_MSHR],
    output mshr_pkg::l2_set_t          set_o   [mshr_pkg::N_MSHR],
    // read port
    output mshr_pkg::spx_state_e       rd_state_o,
    output mshr_pkg::l2_tag_t          rd_tag_o,
    output mshr_pkg::l2_set_t          rd_set_o,
    output mshr_pkg::line_t            rd_line_o,
    output mshr_pkg::word_mask_t       rd_word_mask_o,
    // drain status
    output logic                       write_pending_o
);

    // per-field storage
    mshr_pkg::spx_state_e state_q [mshr_pkg::N_MSHR];
    mshr_pkg::l2_tag_t    tag_q   [mshr_pkg::N_MSHR];
    mshr_pkg::l2_set_t    set_q   [mshr_pkg::N_MSHR];
    mshr_pkg::line_t      line_q  [mshr_pkg::N_MSHR];
    mshr_pkg::word_mask_t mask_q  [mshr_pkg::N_MSHR];

    for (genvar i = 0; i < mshr_pkg::N_MSHR; i++) begin : g_entry
        logic sel;

        // slot addressed by the latched index
        assign sel = (wr_idx_i == mshr_pkg::mshr_idx_t'(i));

        // state
        always_ff @(posedge clk or negedge rst) begin
            if (!rst) begin
                state_q[i] <= mshr_pkg::SPX_I;
            end else if (sel && (add_entry_i || upd_state_i)) begin
                state_q[i] <= state_i;
            end
        end

        // tag
        always_ff @(posedge clk or negedge rst) begin
            if (!rst) begin
                tag_q[i] <= '0;
            end else if (sel && (add_entry_i || upd_tag_i)) begin
                tag_q[i] <= tag_i;
            end
        end

        // set only changes on add
        always_ff @(posedge clk or negedge rst) begin
            if (!rst) begin
                set_q[i] <= '0;
            end else if (sel && add_entry_i) begin
                set_q[i] <= set_i;
            end
        end

        // line data
        always_ff @(posedge clk or negedge rst) begin
            if (!rst) begin
                line_q[i] <= '0;
            end else if (sel && (add_entry_i || upd_line_i)) begin
                line_q[i] <= line_i;
            end
        end

        // word mask
        always_ff @(posedge clk or negedge rst) begin
            if (!rst) begin
                mask_q[i] <= '0;
            end else if (sel && (add_entry_i || upd_word_mask_i)) begin
                mask_q[i] <= word_mask_i;
            end
        end
    end

    assign state_o = state_q;
    assign tag_o   = tag_q;
    assign set_o   = set_q;

    // combinational read port
    assign rd_state_o     = state_q[rd_idx_i];
    assign rd_tag_o       = tag_q[rd_idx_i];
    assign rd_set_o       = set_q[rd_idx_i];
    assign rd_line_o      = line_q[rd_idx_i];
    assign rd_word_mask_o = mask_q[rd_idx_i];

    // ownership or atomic still outstanding
    always_comb begin
        write_pending_o = 1'b0;
        for (int i = 0; i < mshr_pkg::N_MSHR; i++) begin
            if (state_q[i] inside {mshr_pkg::SPX_XR, mshr_pkg::SPX_XRV, mshr_pkg::SPX_AMO}) begin
                write_pending_o = 1'b1;
            end
        end
    end

    // the index comes from the last peek, which picked a free slot
    a_add_to_free: assert property (@(posedge clk) disable iff (!rst)
        add_entry_i |-> (state_q[wr_idx_i] == mshr_pkg::SPX_I))
        else $error("add targets live mshr entry %0d", wr_idx_i);

endmodule

// File: design/mshr_pkg.sv
package mshr_pkg;

    // table geometry
    localparam int N_MSHR         = 4;
    localparam int MSHR_BITS      = 2;
    // address split of an l2 line
    localparam int TAG_BITS       = 12;
    localparam int SET_BITS       = 6;
    // line layout
    localparam int WORDS_PER_LINE = 4;
    localparam int WORD_BITS      = 32;

    typedef logic [MSHR_BITS-1:0]                mshr_idx_t;
    typedef logic [TAG_BITS-1:0]                 l2_tag_t;
    typedef logic [SET_BITS-1:0]                 l2_set_t;
    typedef logic [WORDS_PER_LINE*WORD_BITS-1:0] line_t;
    // one bit per word of the line
    typedef logic [WORDS_PER_LINE-1:0]           word_mask_t;

    // transient coherence states where SPX_I marks a free slot
    typedef enum logic [3:0] {
        SPX_I   = 4'd0,
        SPX_IS  = 4'd1,
        SPX_II  = 4'd2,
        SPX_RI  = 4'd3,
        SPX_XR  = 4'd4,
        SPX_XRV = 4'd5,
        SPX_AMO = 4'd6
    } spx_state_e;

    // operations issued by the l2 fsm
    typedef enum logic [2:0] {
        MSHR_IDLE       = 3'd0,
        MSHR_LOOKUP     = 3'd1,
        MSHR_PEEK_REQ   = 3'd2,
        MSHR_PEEK_FLUSH = 3'd3,
        MSHR_PEEK_FWD   = 3'd4
    } mshr_op_e;

    // incoming forward messages seen by peek_fwd
    typedef enum logic [2:0] {
        FWD_INV       = 3'd0,
        FWD_RVK_O     = 3'd1,
        FWD_REQ_S     = 3'd2,
        FWD_REQ_ODATA = 3'd3,
        FWD_WTFWD     = 3'd4
    } fwd_msg_e;

endpackage

// File: design/mshr_search.sv
`timescale 1ns/1ps

module mshr_search (
    input  logic                    clk,
    input  logic                    rst,
    // operation strobe and its operands
    input  mshr_pkg::mshr_op_e      op_i,
    input  mshr_pkg::l2_tag_t       tag_i,
    input  mshr_pkg::l2_set_t       set_i,
    input  mshr_pkg::fwd_msg_e      fwd_msg_i,
    // current table contents
    input  mshr_pkg::spx_state_e    state_i [mshr_pkg::N_MSHR],
    input  mshr_pkg::l2_tag_t       tag_e_i [mshr_pkg::N_MSHR],
    input  mshr_pkg::l2_set_t       set_e_i [mshr_pkg::N_MSHR],
    // same-cycle strobes
    output logic                    set_conflict_o,
    output logic                    clr_conflict_o,
    output logic                    set_fwd_stall_o,
    output logic                    clr_fwd_stall_o,
    output mshr_pkg::mshr_idx_t     stall_idx_o,
    // latched result
    output mshr_pkg::mshr_idx_t     mshr_idx_o,
    output logic                    mshr_hit_o
);

    logic [mshr_pkg::N_MSHR-1:0] valid_vec;
    logic [mshr_pkg::N_MSHR-1:0] match_vec;
    logic [mshr_pkg::N_MSHR-1:0] same_set_vec;
    logic                        match_any;
    mshr_pkg::mshr_idx_t         match_idx;
    mshr_pkg::mshr_idx_t         free_idx;
    mshr_pkg::spx_state_e        hit_state;
    logic                        fwd_override;
    mshr_pkg::mshr_idx_t         idx_next;
    logic                        hit_next;

    // parallel compare against every entry
    always_comb begin
        for (int i = 0; i < mshr_pkg::N_MSHR; i++) begin
            valid_vec[i]    = (state_i[i] != mshr_pkg::SPX_I);
            same_set_vec[i] = valid_vec[i] && (set_e_i[i] == set_i);
            match_vec[i]    = same_set_vec[i] && (tag_e_i[i] == tag_i);
        end
    end

    // highest index wins for both hit and free slot
    always_comb begin
        match_any = 1'b0;
        match_idx = '0;
        free_idx  = '0;
        for (int i = 0; i < mshr_pkg::N_MSHR; i++) begin
            if (match_vec[i]) begin
                match_any = 1'b1;
                match_idx = mshr_pkg::mshr_idx_t'(i);
            end
            if (!valid_vec[i]) begin
                free_idx = mshr_pkg::mshr_idx_t'(i);
            end
        end
    end

    assign hit_state = state_i[match_idx];

    // forwards that are answered at once instead of stalling
    always_comb begin
        case (fwd_msg_i)
            mshr_pkg::FWD_INV: begin
                fwd_override = 1'b1;
            end
            mshr_pkg::FWD_RVK_O, mshr_pkg::FWD_REQ_S, mshr_pkg::FWD_REQ_ODATA: begin
                fwd_override = (hit_state == mshr_pkg::SPX_RI);
            end
            default: begin
                fwd_override = 1'b0;
            end
        endcase
    end

    // per-opcode decisions
    always_comb begin
        set_conflict_o  = 1'b0;
        clr_conflict_o  = 1'b0;
        set_fwd_stall_o = 1'b0;
        clr_fwd_stall_o = 1'b0;
        stall_idx_o     = '0;
        idx_next        = '0;
        hit_next        = 1'b0;
        case (op_i)
            mshr_pkg::MSHR_LOOKUP: begin
                idx_next = match_idx;
                hit_next = match_any;
            end
            mshr_pkg::MSHR_PEEK_REQ: begin
                // any live entry on the same set blocks the request
                set_conflict_o = |same_set_vec;
                clr_conflict_o = ~|same_set_vec;
                idx_next       = free_idx;
            end
            mshr_pkg::MSHR_PEEK_FLUSH: begin
                idx_next = free_idx;
            end
            mshr_pkg::MSHR_PEEK_FWD: begin
                idx_next = match_idx;
                hit_next = match_any;
                if (match_any && !fwd_override) begin
                    set_fwd_stall_o = 1'b1;
                    stall_idx_o     = match_idx;
                end else begin
                    clr_fwd_stall_o = 1'b1;
                end
            end
            default: begin
                hit_next = 1'b0;
            end
        endcase
    end

    // idle keeps the last result
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            mshr_idx_o <= '0;
            mshr_hit_o <= 1'b0;
        end else if (op_i != mshr_pkg::MSHR_IDLE) begin
            mshr_idx_o <= idx_next;
            mshr_hit_o <= hit_next;
        end
    end

    // the l2 fsm only drives defined opcodes
    a_op_legal: assert property (@(posedge clk) disable iff (!rst)
        op_i inside {mshr_pkg::MSHR_IDLE, mshr_pkg::MSHR_LOOKUP, mshr_pkg::MSHR_PEEK_REQ,
                     mshr_pkg::MSHR_PEEK_FLUSH, mshr_pkg::MSHR_PEEK_FWD})
        else $error("illegal mshr opcode %0d", op_i);

endmodule

// File: l2_mshr.f
+incdir+bench
design/mshr_pkg.sv
design/mshr_entry_table.sv
design/mshr_search.sv
design/l2_mshr.sv
bench/tb_l2_mshr.sv
